/* all.f */
+incdir+include
design/exec_pkg.sv
design/alu.sv
design/forward_unit.sv
design/execute.sv
design/exec_top.sv
verif/exec_tb.sv

/* Makefile */
VERILATOR ?= verilator
FLAGS     = --binary --timing -j 0
TOP       = exec_tb
FILELIST  = all.f
BUILD_DIR = obj_dir
LOG       = sim.log
PASS_MSG  = test passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, search the log for the pass line"
	@echo "  clean  remove build output and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "^$(PASS_MSG)$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* include/exec_model.svh */
`ifndef EXEC_MODEL_SVH
`define EXEC_MODEL_SVH

// Reference ALU
function automatic word_t alu_result(alu_op_t op, word_t a, word_t b);
    case (op)
        ADD:     return a + b;
        SUB:     return a - b;
        SLL:     return a << b[4:0];
        SLT:     return {31'b0, $signed(a) < $signed(b)};
        SLTU:    return {31'b0, a < b};
        XOR:     return a ^ b;
        SRL:     return a >> b[4:0];
        SRA:     return word_t'($signed(a) >>> b[4:0]);
        OR:      return a | b;
        AND:     return a & b;
        default: return '0;
    endcase
endfunction

function automatic logic branch_taken(branch_op_t op, word_t a, word_t b);
    case (op)
        BEQ:     return a == b;
        BNE:     return a != b;
        BLT:     return $signed(a) < $signed(b);
        BGE:     return $signed(a) >= $signed(b);
        BLTU:    return a < b;
        BGEU:    return a >= b;
        default: return 1'b0;
    endcase
endfunction

// Operand value after bypass with EX ahead of MEM
function automatic word_t forwarded(reg_idx_t src, word_t value, ex_out_t ex, ex_out_t mem);
    if (src != '0 && ex.valid && ex.ctrl.reg_write && ex.ctrl.rd == src)
        return ex.result;
    if (src != '0 && mem.valid && mem.ctrl.reg_write && mem.ctrl.rd == src)
        return mem.result;
    return value;
endfunction

// Result word by class from bypassed operands
function automatic word_t class_result(issue_t i);
    case (i.op_class)
        LOAD_STORE: return i.rs1_value + i.imm;
        BRANCH:     return i.rs1_value - i.rs2_value;
        REG_IMM:    return alu_result(i.alu_op, i.rs1_value, i.alu_src ? i.imm : i.rs2_value);
        LUI:        return i.imm;
        AUIPC:      return i.pc + i.imm;
        default:    return i.pc + 32'd4;  // Link value
    endcase
endfunction

function automatic logic redirects(issue_t i);
    case (i.op_class)
        BRANCH:    return branch_taken(i.branch_op, i.rs1_value, i.rs2_value);
        JAL, JALR: return 1'b1;
        default:   return 1'b0;
    endcase
endfunction

// Only meaningful when redirects is set
function automatic word_t redirect_target(issue_t i);
    word_t sum;
    sum = i.rs1_value + i.imm;
    case (i.op_class)
        BRANCH:  return i.pc + {{20{i.branch_offset[11]}}, i.branch_offset};
        JALR:    return {sum[31:1], 1'b0};
        default: return i.pc + i.imm;
    endcase
endfunction

`endif

/* verif/exec_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module exec_tb;
    import exec_pkg::*;

    `include "exec_model.svh"

    localparam int CLK_PERIOD  = 40;
    localparam int NUM_INSTR   = 2000;
    localparam int RESET_LIMIT = 10;    // Cycles allowed until reset is released

    logic       clk;
    logic       rst;
    issue_t     issue;
    ex_out_t    ex_out;

    integer     seed;
    int         waited;
    reg_idx_t   load_rd;                // Destination of the previous load or 0
    issue_t     ins;
    ex_out_t    exp_ex;                 // Expected output of the instruction in EX
    ex_out_t    exp_mem;                // One position older in MEM
    ex_out_t    exp_next;
    branch_op_t bops [6] = '{BEQ, BNE, BLT, BGE, BLTU, BGEU};

    exec_top UUT (
        .clk    (clk),
        .rst    (rst),
        .issue  (issue),
        .ex_out (ex_out)
    );

    initial
    begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Reset held for two cycles and released off the clock edge
    initial
    begin
        rst   = 1'b1;
        issue = '0;
        repeat (2) @(posedge clk);
        #2;
        rst = 1'b0;
    end

    // Guard against a stuck run
    initial
    begin
        #(CLK_PERIOD * (NUM_INSTR + RESET_LIMIT + 100));
        $display("simulation did not finish within the time limit");
        $display("test failed");
        $fatal(1);
    end

    task automatic check_word(input string name, input word_t exp, input word_t act);
        if (act !== exp)
        begin
            $display("error %s expected %h actual %h", name, exp, act);
            $display("test failed");
            $fatal(1);
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp)
        begin
            $display("error %s expected %h actual %h", name, exp, act);
            $display("test failed");
            $fatal(1);
        end
    endtask

    task automatic check_ctrl(input string name, input ctrl_t exp, input ctrl_t act);
        if (act !== exp)
        begin
            $display("error %s expected %h actual %h", name, exp, act);
            $display("test failed");
            $fatal(1);
        end
    endtask

    function automatic int rand_below(int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    function automatic word_t rand_word();
        return word_t'($random(seed));
    endfunction

    // One random instruction with about one in ten a bubble
    task automatic make_instr(output issue_t i);
        word_t w;
        word_t p;
        i             = '0;
        i.valid       = (rand_below(10) != 0);
        i.op_class    = op_class_t'(rand_below(7));
        i.alu_op      = alu_op_t'(rand_below(10));
        i.alu_src     = (rand_below(2) == 1);
        i.branch_op   = bops[rand_below(6)];
        i.rs1         = reg_idx_t'(rand_below(8));  // Small range gives frequent dependences
        i.rs2         = reg_idx_t'(rand_below(8));
        i.rs1_value   = rand_word();
        i.rs2_value   = (rand_below(4) == 0) ? i.rs1_value : rand_word();  // Equal operands
        w             = rand_word();
        i.imm         = (rand_below(2) == 0) ? w : {{20{w[11]}}, w[11:0]};
        p             = rand_word();
        i.pc          = {p[31:2], 2'b00};
        w             = rand_word();
        i.branch_offset = boff_t'({w[11:1], 1'b0});
        i.ctrl.rd     = reg_idx_t'(rand_below(8));
        case (i.op_class)
            LOAD_STORE:
            begin
                i.ctrl.mem_read   = (rand_below(2) == 1);
                i.ctrl.mem_write  = !i.ctrl.mem_read;
                i.ctrl.reg_write  = i.ctrl.mem_read;
                i.ctrl.mem_to_reg = i.ctrl.mem_read;
            end
            BRANCH:
                i.ctrl.reg_write = 1'b0;
            default:
                i.ctrl.reg_write = (rand_below(8) != 0);  // Some results not written
        endcase
    endtask

    // Expected stage output with operands bypassed from the older two
    function automatic ex_out_t expect_out(issue_t i, ex_out_t ex, ex_out_t mem);
        issue_t  f;
        ex_out_t e;
        e           = '0;
        f           = i;
        f.rs1_value = forwarded(i.rs1, i.rs1_value, ex, mem);
        f.rs2_value = forwarded(i.rs2, i.rs2_value, ex, mem);
        if (i.valid)
        begin
            e.valid       = 1'b1;
            e.ctrl        = f.ctrl;
            e.result      = class_result(f);
            e.store_data  = f.rs2_value;
            e.pc_redirect = redirects(f);
            e.target      = redirect_target(f);
        end
        return e;
    endfunction

    task automatic compare_output(input ex_out_t e);
        check_bit("ex_out.valid", e.valid, ex_out.valid);
        check_bit("ex_out.pc_redirect", e.pc_redirect, ex_out.pc_redirect);
        if (e.valid)
        begin
            check_ctrl("ex_out.ctrl", e.ctrl, ex_out.ctrl);
            check_word("ex_out.result", e.result, ex_out.result);
            check_word("ex_out.store_data", e.store_data, ex_out.store_data);
            if (e.pc_redirect)
                check_word("ex_out.target", e.target, ex_out.target);  // Ignored otherwise
        end
        else
        begin
            // Bubble shows no enables
            check_bit("ex_out.ctrl.mem_write", 1'b0, ex_out.ctrl.mem_write);
            check_bit("ex_out.ctrl.mem_read", 1'b0, ex_out.ctrl.mem_read);
            check_bit("ex_out.ctrl.reg_write", 1'b0, ex_out.ctrl.reg_write);
        end
    endtask

    initial
    begin
        seed    = 32'h4b7995d4;
        waited  = 0;
        load_rd = '0;
        exp_ex  = '0;
        exp_mem = '0;

        while (rst !== 1'b0 && waited < RESET_LIMIT)
        begin
            @(posedge clk);
            #1;
            check_bit("ex_out.valid", 1'b0, ex_out.valid);              // Idle in reset
            check_bit("ex_out.pc_redirect", 1'b0, ex_out.pc_redirect);
            waited++;
        end
        if (rst !== 1'b0)
        begin
            $display("reset was not released within %0d cycles", RESET_LIMIT);
            $display("test failed");
            $fatal(1);
        end

        for (int k = 0; k <= NUM_INSTR; k++)
        begin
            @(posedge clk);
            #1;
            compare_output(exp_ex);     // Instruction captured at this edge
            #1;
            if (k < NUM_INSTR)
                make_instr(ins);
            else
                ins = '0;               // Drain with a bubble

            // No use right behind a load
            if (load_rd != '0 && ins.rs1 == load_rd)
                ins.rs1 = load_rd ^ 5'd1;
            if (load_rd != '0 && ins.rs2 == load_rd)
                ins.rs2 = load_rd ^ 5'd1;
            load_rd = (ins.valid && ins.ctrl.mem_read && ins.ctrl.reg_write) ? ins.ctrl.rd : '0;

            issue    = ins;
            exp_next = expect_out(ins, exp_ex, exp_mem);
            exp_mem  = exp_ex;          // Pipeline advances at the next edge
            exp_ex   = exp_next;
        end

        $display("test passed");
        $finish;
    end

endmodule

`default_nettype wire

/* design/exec_top.sv */
`default_nettype none
`timescale 1ns/10ps

module exec_top (
    input  wire logic             clk,
    input  wire logic             rst,
    input  wire exec_pkg::issue_t issue,   // From decode, valid low is a bubble
    output exec_pkg::ex_out_t     ex_out   // To MEM and fetch
);
    import exec_pkg::*;

    issue_t issue_fwd;  // Issue with bypassed operands

    // Bypass from EX and MEM positions
    forward_unit u_forward (
        .clk       (clk),
        .rst       (rst),
        .issue     (issue),
        .ex_out    (ex_out),
        .issue_fwd (issue_fwd)
    );

    // ID/EX register and execute logic
    execute u_execute (
        .clk    (clk),
        .rst    (rst),
        .issue  (issue_fwd),
        .ex_out (ex_out)
    );

endmodule

`default_nettype wire

/* design/execute.sv */
`default_nettype none
`timescale 1ns/10ps

module execute (
    input  wire logic             clk,
    input  wire logic             rst,
    input  wire exec_pkg::issue_t issue,
    output exec_pkg::ex_out_t     ex_out
);
    import exec_pkg::*;

    logic    id_ex_valid;   // Stage holds an instruction
    issue_t  id_ex;         // ID/EX payload
    alu_op_t alu_op;
    word_t   alu_a;
    word_t   alu_b;
    word_t   alu_y;
    logic    alu_zero;
    logic    alu_borrow;
    logic    lt_signed;     // rs1 < rs2 as signed
    logic    taken;
    logic    redirect;
    logic    is_jalr;
    word_t   tgt_base;
    word_t   tgt_off;
    word_t   tgt_sum;

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            id_ex_valid <= 1'b0;
        end
        else
        begin
            id_ex_valid <= issue.valid;
        end
    end

    always_ff @(posedge clk)
    begin
        id_ex <= issue;
    end

    // Operand and function select by class
    always_comb
    begin
        case (id_ex.op_class)
            BRANCH:
            begin
                alu_a  = id_ex.rs1_value;
                alu_b  = id_ex.rs2_value;
                alu_op = SUB;           // Flags drive the compare
            end
            REG_IMM:
            begin
                alu_a  = id_ex.rs1_value;
                alu_b  = id_ex.alu_src ? id_ex.imm : id_ex.rs2_value;
                alu_op = id_ex.alu_op;
            end
            LUI:
            begin
                alu_a  = '0;            // Result is imm itself
                alu_b  = id_ex.imm;
                alu_op = ADD;
            end
            AUIPC:
            begin
                alu_a  = id_ex.pc;
                alu_b  = id_ex.imm;
                alu_op = ADD;
            end
            JAL, JALR:
            begin
                alu_a  = id_ex.pc;      // Link value pc + 4
                alu_b  = 32'd4;
                alu_op = ADD;
            end
            default:
            begin
                // LOAD_STORE effective address
                alu_a  = id_ex.rs1_value;
                alu_b  = id_ex.imm;
                alu_op = ADD;
            end
        endcase
    end

    alu u_alu (
        .op     (alu_op),
        .a      (alu_a),
        .b      (alu_b),
        .y      (alu_y),
        .zero   (alu_zero),
        .borrow (alu_borrow)
    );

    // Sign of the difference, flipped on overflow
    assign lt_signed = alu_y[31] ^ ((alu_a[31] ^ alu_b[31]) & (alu_y[31] ^ alu_a[31]));

    always_comb
    begin
        case (id_ex.branch_op)
            BEQ:     taken = alu_zero;
            BNE:     taken = !alu_zero;
            BLT:     taken = lt_signed;
            BGE:     taken = !lt_signed;
            BLTU:    taken = alu_borrow;
            BGEU:    taken = !alu_borrow;
            default: taken = 1'b0;
        endcase

        case (id_ex.op_class)
            BRANCH:    redirect = taken;
            JAL, JALR: redirect = 1'b1;
            default:   redirect = 1'b0;
        endcase
    end

    // One adder serves branch, JAL and JALR targets
    assign is_jalr  = (id_ex.op_class == JALR);
    assign tgt_base = is_jalr ? id_ex.rs1_value : id_ex.pc;
    assign tgt_off  = (id_ex.op_class == BRANCH) ?
                      {{20{id_ex.branch_offset[11]}}, id_ex.branch_offset} : id_ex.imm;
    assign tgt_sum  = tgt_base + tgt_off;

    always_comb
    begin
        ex_out                = '0;
        ex_out.valid          = id_ex_valid;
        ex_out.ctrl           = id_ex.ctrl;
        ex_out.ctrl.mem_write = id_ex.ctrl.mem_write & id_ex_valid;  // Bubbles write nothing
        ex_out.ctrl.mem_read  = id_ex.ctrl.mem_read & id_ex_valid;
        ex_out.ctrl.reg_write = id_ex.ctrl.reg_write & id_ex_valid;
        ex_out.result         = alu_y;
        ex_out.store_data     = id_ex.rs2_value;
        ex_out.pc_redirect    = redirect & id_ex_valid;
        ex_out.target         = {tgt_sum[31:1], tgt_sum[0] & !is_jalr};  // JALR clears bit 0
    end

endmodule

`default_nettype wire

/* design/forward_unit.sv */
`default_nettype none
`timescale 1ns/10ps

module forward_unit (
    input  wire logic              clk,
    input  wire logic              rst,
    input  wire exec_pkg::issue_t  issue,
    input  wire exec_pkg::ex_out_t ex_out,
    output exec_pkg::issue_t       issue_fwd
);
    import exec_pkg::*;

    logic  mem_valid;   // MEM position holds a real instruction
    ctrl_t mem_ctrl;
    word_t mem_result;

    // Source matches a producer that will write the register file
    function automatic logic hits(reg_idx_t src, logic valid, ctrl_t c);
        return valid && c.reg_write && (src != '0) && (src == c.rd);
    endfunction

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            mem_valid <= 1'b0;
        end
        else
        begin
            mem_valid <= ex_out.valid;
        end
    end

    // Payload of the MEM position, qualified by mem_valid
    always_ff @(posedge clk)
    begin
        mem_ctrl   <= ex_out.ctrl;
        mem_result <= ex_out.result;
    end

    always_comb
    begin
        issue_fwd = issue;  // Everything but the operands passes as is

        // EX is younger than MEM so it wins
        if (hits(issue.rs1, ex_out.valid, ex_out.ctrl))
            issue_fwd.rs1_value = ex_out.result;
        else if (hits(issue.rs1, mem_valid, mem_ctrl))
            issue_fwd.rs1_value = mem_result;

        if (hits(issue.rs2, ex_out.valid, ex_out.ctrl))
            issue_fwd.rs2_value = ex_out.result;
        else if (hits(issue.rs2, mem_valid, mem_ctrl))
            issue_fwd.rs2_value = mem_result;
    end

endmodule

`default_nettype wire

/* design/alu.sv */
`default_nettype none
`timescale 1ns/10ps

module alu (
    input  wire exec_pkg::alu_op_t op,
    input  wire exec_pkg::word_t   a,
    input  wire exec_pkg::word_t   b,
    output exec_pkg::word_t        y,
    output logic                   zero,
    output logic                   borrow
);
    import exec_pkg::*;

    logic [32:0] diff;   // a - b with room for the borrow out
    logic [4:0]  shamt;  // RV32 shifts use 5 bits
    logic        lt_s;

    assign diff  = {1'b0, a} - {1'b0, b};
    assign shamt = b[4:0];
    assign lt_s  = $signed(a) < $signed(b);

    always_comb
    begin
        case (op)
            ADD:
                y = a + b;
            SUB:
                y = diff[31:0];
            SLL:
                y = a << shamt;
            SLT:
                y = {31'b0, lt_s};
            SLTU:
                y = {31'b0, diff[32]};      // Unsigned less-than is the borrow
            XOR:
                y = a ^ b;
            SRL:
                y = a >> shamt;
            SRA:
                y = word_t'($signed(a) >>> shamt);
            OR:
                y = a | b;
            AND:
                y = a & b;
            default:
                y = '0;                     // Unused op codes
        endcase
    end

    // Flags for branch resolution, valid when op is SUB
    assign zero   = (y == '0);
    assign borrow = diff[32];   // Set when a < b unsigned

endmodule

`default_nettype wire

/* design/exec_pkg.sv */
`default_nettype none

package exec_pkg;

    typedef logic [31:0]        word_t;     // Data or address word
    typedef logic [4:0]         reg_idx_t;  // x0 always reads as zero
    typedef logic signed [11:0] boff_t;     // Branch byte offset, sign-extended at use

    // ALU function select
    typedef enum logic [3:0] {
        ADD  = 4'd0,
        SUB  = 4'd1,
        SLL  = 4'd2,
        SLT  = 4'd3,
        SLTU = 4'd4,
        XOR  = 4'd5,
        SRL  = 4'd6,
        SRA  = 4'd7,
        OR   = 4'd8,
        AND  = 4'd9
    } alu_op_t;

    // Instruction class, picks operands and PC behavior
    typedef enum logic [2:0] {
        LOAD_STORE = 3'd0,
        BRANCH     = 3'd1,
        REG_IMM    = 3'd2,
        LUI        = 3'd3,
        AUIPC      = 3'd4,
        JAL        = 3'd5,
        JALR       = 3'd6
    } op_class_t;

    // Branch condition, RISC-V funct3 codes
    typedef enum logic [2:0] {
        BEQ  = 3'b000,
        BNE  = 3'b001,
        BLT  = 3'b100,
        BGE  = 3'b101,
        BLTU = 3'b110,
        BGEU = 3'b111
    } branch_op_t;

    // Controls consumed by MEM and WB
    typedef struct packed {
        logic     mem_write;
        logic     mem_read;
        logic     reg_write;
        reg_idx_t rd;          // Destination register
        logic     mem_to_reg;  // WB takes load data instead of result
    } ctrl_t;

    typedef struct packed {
        logic       valid;          // Low for a bubble
        op_class_t  op_class;
        alu_op_t    alu_op;         // Used by REG_IMM only
        logic       alu_src;        // 1 selects imm as second operand
        branch_op_t branch_op;
        reg_idx_t   rs1;
        reg_idx_t   rs2;
        word_t      rs1_value;
        word_t      rs2_value;
        word_t      imm;
        word_t      pc;
        boff_t      branch_offset;
        ctrl_t      ctrl;
    } issue_t;

    typedef struct packed {
        logic  valid;
        ctrl_t ctrl;
        word_t result;       // ALU result, address or link value
        word_t store_data;   // rs2 for stores
        logic  pc_redirect;  // Taken branch or jump
        word_t target;       // New PC when redirecting
    } ex_out_t;

endpackage

`default_nettype wire
